// ==== source/fq_types_pkg.sv ====
// Fault queue types
package fq_types_pkg;

    localparam int unsigned IOVA_W         = 64;  // Faulting IOVA
    localparam int unsigned GPA_W          = 41;  // GPA bits from 2 upward
    localparam int unsigned PPN_W          = 44;  // Queue base page number
    localparam int unsigned PADDR_W        = 56;  // Physical address
    localparam int unsigned DID_W          = 24;
    localparam int unsigned PID_W          = 20;
    localparam int unsigned CAUSE_W        = 12;
    localparam int unsigned TTYP_W         = 6;
    localparam int unsigned IDX_W          = 32;  // Head and tail indexes
    localparam int unsigned SIZE_W         = 5;   // Queue size as log2 minus one
    localparam int unsigned REC_BYTES_LOG2 = 5;   // 32-byte records
    localparam int unsigned BUF_DEPTH      = 4;   // Pending events

    // Transaction types reported in TTYP
    typedef enum logic [TTYP_W-1:0] {
        TTYP_NONE  = 6'd0,
        UNTR_EXEC  = 6'd1,
        UNTR_READ  = 6'd2,
        UNTR_WRITE = 6'd3,
        TR_EXEC    = 6'd5,
        TR_READ    = 6'd6,
        TR_WRITE   = 6'd7,
        PCIE_ATS   = 6'd8,
        PCIE_MSG   = 6'd9   // Message requests, only the code is known here
    } ttyp_e;

    // Fault event from the translation logic
    typedef struct packed {
        ttyp_e              ttyp;
        logic [CAUSE_W-1:0] cause;
        logic [IOVA_W-1:0]  iova;
        logic [GPA_W-1:0]   gpa;       // GPA[63:2] of a guest page fault
        logic [DID_W-1:0]   did;
        logic               pv;        // pid is valid
        logic [PID_W-1:0]   pid;
        logic               priv;      // Supervisor access
        logic               guest_pf;
        logic               implicit;  // Implicit access for first-stage walk
    } fq_event_t;

    // Fault record, DW3 down to DW0
    typedef struct packed {
        logic [IOVA_W-1:0]  iotval2;   // DW3
        logic [IOVA_W-1:0]  iotval;    // DW2
        logic [IOVA_W-1:0]  rsvd;      // DW1, always zero
        logic [DID_W-1:0]   did;       // DW0[63:40]
        ttyp_e              ttyp;      // DW0[39:34]
        logic               priv;      // DW0[33]
        logic               pv;        // DW0[32]
        logic [PID_W-1:0]   pid;       // DW0[31:12]
        logic [CAUSE_W-1:0] cause;     // DW0[11:0]
    } fq_record_t;

    // Register map to handler
    typedef struct packed {
        logic [PPN_W-1:0]  base_ppn;
        logic [SIZE_W-1:0] size;
        logic              en;
        logic              ie;
        logic [IDX_W-1:0]  head;
        logic [IDX_W-1:0]  tail;
        logic              mf;
        logic              of;
    } fq_regs_t;

    // Handler to register map
    typedef struct packed {
        logic [IDX_W-1:0] tail;
        logic             on;
        logic             busy;
        logic             mf;
        logic             of;
        logic             ip;   // Interrupt pending pulse
        logic             wen;  // Write strobe for tail, mf and of
    } fq_status_t;

endpackage

// ==== source/fq_bus_pkg.sv ====
// Fault queue write bus
package fq_bus_pkg;

    localparam int unsigned BEAT_W = 64;  // One doubleword per beat
    localparam int unsigned BEATS  = 4;   // One record per burst

    // Write response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Master to memory
    typedef struct packed {
        logic                               aw_valid;
        logic [fq_types_pkg::PADDR_W-1:0]   aw_addr;   // Burst start
        logic                               w_valid;
        logic [BEAT_W-1:0]                  w_data;
        logic                               w_last;
        logic                               b_ready;
    } wr_req_t;

    // Memory to master
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_e b_resp;
    } wr_rsp_t;

endpackage

// ==== source/fq_event_buffer.sv ====
// Fault event buffer
`timescale 1ns/1ps

module fq_event_buffer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    event_valid_i,
    input  fq_types_pkg::fq_event_t event_i,
    input  logic                    pop_i,
    output fq_types_pkg::fq_event_t head_o,
    output logic                    empty_o,
    output logic                    full_o
);

    localparam int unsigned PTR_W = $clog2(fq_types_pkg::BUF_DEPTH);
    localparam int unsigned CNT_W = $clog2(fq_types_pkg::BUF_DEPTH + 1);

    fq_types_pkg::fq_event_t mem_q [fq_types_pkg::BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             valid_q;       // Last event_valid_i
    logic             push;
    logic             stored_empty;
    logic             do_write, do_read;

    assign push         = event_valid_i & ~valid_q & ~full_o;  // Rising edge only
    assign stored_empty = (count_q == '0);
    assign full_o       = (count_q == CNT_W'(fq_types_pkg::BUF_DEPTH));

    // Fall through an empty ring
    assign empty_o = stored_empty & ~push;
    assign head_o  = stored_empty ? event_i : mem_q[rd_ptr_q];

    // Pushed event that leaves in the same cycle is never stored
    assign do_write = push & ~(pop_i & stored_empty);
    assign do_read  = pop_i & ~stored_empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            valid_q <= event_valid_i;
            if (do_write) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
            if (do_read)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(do_write) - CNT_W'(do_read);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_write) mem_q[wr_ptr_q] <= event_i;
    end

    // Controller pops only a head it has seen
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o)
        else $error("Event buffer popped while empty");

endmodule

// ==== source/fq_record_builder.sv ====
// Fault record formatting
`timescale 1ns/1ps

module fq_record_builder (
    input  fq_types_pkg::fq_event_t  event_i,
    output fq_types_pkg::fq_record_t record_o
);

    localparam int unsigned GPA_PAD_W = fq_types_pkg::IOVA_W - fq_types_pkg::GPA_W - 2;

    always_comb begin
        record_o       = '0;
        record_o.cause = event_i.cause;  // Always reported
        record_o.ttyp  = event_i.ttyp;

        if (event_i.ttyp == fq_types_pkg::TTYP_NONE) begin
            // IOMMU-generated access, no requester fields
            record_o.iotval = event_i.iova;
        end else begin
            record_o.did  = event_i.did;
            record_o.pv   = event_i.pv;
            record_o.pid  = event_i.pv ? event_i.pid : '0;  // pid only when valid
            record_o.priv = event_i.pv & event_i.priv;
            // Message requests carry no address
            if (event_i.ttyp != fq_types_pkg::PCIE_MSG) begin
                record_o.iotval = event_i.iova;
            end
        end

        // Guest page fault reports GPA in iotval2[63:2]
        if (event_i.guest_pf) begin
            record_o.iotval2 = {{GPA_PAD_W{1'b0}}, event_i.gpa,
                                1'b0,              // No A/D update
                                event_i.implicit};
        end
    end

endmodule

// ==== source/fq_queue_ctrl.sv ====
// Fault queue controller
`timescale 1ns/1ps

module fq_queue_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  fq_types_pkg::fq_regs_t              regs_i,
    input  fq_types_pkg::fq_record_t            head_record_i,
    input  logic                                buf_empty_i,
    input  logic                                wr_done_i,
    input  logic                                wr_err_i,
    output fq_types_pkg::fq_status_t            status_o,
    output logic                                buf_pop_o,
    output logic                                wr_start_o,
    output fq_types_pkg::fq_record_t            wr_record_o,
    output logic [fq_types_pkg::PADDR_W-1:0]    wr_addr_o
);

    localparam int unsigned IDX_W   = fq_types_pkg::IDX_W;
    localparam int unsigned PADDR_W = fq_types_pkg::PADDR_W;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        ERROR
    } fq_state_e;

    fq_state_e state_q, state_n;
    logic      en_q, en_n;       // Enable as last seen in IDLE
    logic      capture;

    fq_types_pkg::fq_record_t record_q;
    logic [PADDR_W-1:0]       addr_q;

    logic [IDX_W-1:0]   idx_mask;
    logic [IDX_W-1:0]   tail_masked, tail_next;
    logic [PADDR_W-1:0] tail_offset;
    logic               queue_full;

    // Queue holds 2^(size+1) entries
    assign idx_mask    = ~({IDX_W{1'b1}} << ({1'b0, regs_i.size} + 6'd1));
    assign tail_masked = regs_i.tail & idx_mask;
    assign tail_next   = (regs_i.tail + 1'b1) & idx_mask;
    assign queue_full  = (tail_next == regs_i.head);  // One slot kept free

    assign tail_offset = {{(PADDR_W - IDX_W){1'b0}}, tail_masked}
                         << fq_types_pkg::REC_BYTES_LOG2;

    assign wr_record_o = record_q;
    assign wr_addr_o   = addr_q;

    always_comb begin
        // Pass-through unless a pulse overrides
        status_o.tail = regs_i.tail;
        status_o.mf   = regs_i.mf;
        status_o.of   = regs_i.of;
        status_o.ip   = 1'b0;
        status_o.wen  = 1'b0;
        status_o.busy = (regs_i.en != en_q);  // Enable change not yet taken
        status_o.on   = en_q | regs_i.en;

        state_n    = state_q;
        en_n       = en_q;
        capture    = 1'b0;
        buf_pop_o  = 1'b0;
        wr_start_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (regs_i.en) begin
                    if (!en_q) begin
                        // Enable handshake clears tail and flags
                        status_o.tail = '0;
                        status_o.mf   = 1'b0;
                        status_o.of   = 1'b0;
                        status_o.wen  = 1'b1;
                        en_n          = 1'b1;
                    end else if (!buf_empty_i) begin
                        if (queue_full) begin
                            status_o.of  = 1'b1;  // Event stays buffered
                            status_o.wen = 1'b1;
                            status_o.ip  = regs_i.ie;
                            state_n      = ERROR;
                        end else begin
                            capture    = 1'b1;
                            buf_pop_o  = 1'b1;
                            wr_start_o = 1'b1;
                            state_n    = WRITE;
                        end
                    end
                end else if (en_q) begin
                    en_n = 1'b0;  // Disable taken only between records
                end
            end

            WRITE: begin
                if (wr_done_i) begin
                    status_o.wen = 1'b1;
                    status_o.ip  = regs_i.ie;
                    if (wr_err_i) begin
                        status_o.mf = 1'b1;  // Tail left unchanged
                        state_n     = ERROR;
                    end else begin
                        status_o.tail = tail_next;
                        state_n       = IDLE;
                    end
                end
            end

            ERROR: begin
                // Software must clear both flags
                if (!regs_i.mf && !regs_i.of) state_n = IDLE;
            end

            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            en_q    <= 1'b0;
        end else begin
            state_q <= state_n;
            en_q    <= en_n;
        end
    end

    // Record and address held for the whole burst
    always_ff @(posedge clk_i) begin
        if (capture) begin
            record_q <= head_record_i;
            addr_q   <= {regs_i.base_ppn, 12'h000} + tail_offset;
        end
    end

    // Buffered head stays until the controller takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !buf_empty_i && !buf_pop_o |=> !buf_empty_i)
        else $error("Buffered event lost before pop");

    // Writer completes only a burst this controller started
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_done_i |-> state_q == WRITE)
        else $error("Write done seen outside WRITE");

endmodule

// ==== source/fq_burst_writer.sv ====
// Fault record burst writer
`timescale 1ns/1ps

module fq_burst_writer (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                start_i,
    input  fq_types_pkg::fq_record_t            record_i,
    input  logic [fq_types_pkg::PADDR_W-1:0]    addr_i,
    input  fq_bus_pkg::wr_rsp_t                 mem_rsp_i,
    output fq_bus_pkg::wr_req_t                 mem_req_o,
    output logic                                done_o,
    output logic                                err_o
);

    localparam int unsigned CNT_W = $clog2(fq_bus_pkg::BEATS);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_phase_e;

    wr_phase_e  phase_q, phase_n;
    logic [CNT_W-1:0] beat_q;   // Doubleword being sent
    logic             last_beat;

    logic [fq_bus_pkg::BEATS-1:0][fq_bus_pkg::BEAT_W-1:0] dwords;

    assign dwords    = record_i;  // DW0 in the low doubleword
    assign last_beat = (beat_q == CNT_W'(fq_bus_pkg::BEATS - 1));

    assign mem_req_o.aw_valid = (phase_q == WR_ADDR);
    assign mem_req_o.aw_addr  = addr_i;
    assign mem_req_o.w_valid  = (phase_q == WR_DATA);
    assign mem_req_o.w_data   = dwords[beat_q];
    assign mem_req_o.w_last   = (phase_q == WR_DATA) & last_beat;
    assign mem_req_o.b_ready  = (phase_q == WR_RESP) & mem_rsp_i.b_valid;  // Only when seen

    assign done_o = mem_req_o.b_ready;
    assign err_o  = done_o & (mem_rsp_i.b_resp != fq_bus_pkg::OKAY);

    always_comb begin
        phase_n = phase_q;
        case (phase_q)
            WR_IDLE: if (start_i) phase_n = WR_ADDR;
            WR_ADDR: if (mem_rsp_i.aw_ready) phase_n = WR_DATA;
            WR_DATA: if (mem_rsp_i.w_ready && last_beat) phase_n = WR_RESP;
            WR_RESP: if (mem_rsp_i.b_valid) phase_n = WR_IDLE;
            default: phase_n = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            phase_q <= phase_n;
            if (phase_q == WR_ADDR) begin
                beat_q <= '0;
            end else if (mem_req_o.w_valid && mem_rsp_i.w_ready) begin
                beat_q <= beat_q + 1'b1;  // Advance on accepted beat
            end
        end
    end

    // Beat held with its data until accepted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.w_valid && !mem_rsp_i.w_ready
        |=> mem_req_o.w_valid && $stable(mem_req_o.w_data))
        else $error("Write beat dropped before ready");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> phase_q == WR_IDLE)
        else $error("Burst start while writer busy");

endmodule

// ==== source/fq_handler.sv ====
// Fault queue handler top
`timescale 1ns/1ps

module fq_handler (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  fq_types_pkg::fq_regs_t      regs_i,
    input  logic                        event_valid_i,
    input  fq_types_pkg::fq_event_t     event_i,
    output fq_types_pkg::fq_status_t    status_o,
    output logic                        is_full_o,
    output fq_bus_pkg::wr_req_t         mem_req_o,
    input  fq_bus_pkg::wr_rsp_t         mem_rsp_i
);

    fq_types_pkg::fq_event_t             head_event;
    fq_types_pkg::fq_record_t            head_record;
    fq_types_pkg::fq_record_t            wr_record;
    logic [fq_types_pkg::PADDR_W-1:0]    wr_addr;
    logic                                buf_empty, buf_pop;
    logic                                wr_start, wr_done, wr_err;

    fq_event_buffer u_buffer (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .event_valid_i ( event_valid_i ),
        .event_i       ( event_i       ),
        .pop_i         ( buf_pop       ),
        .head_o        ( head_event    ),
        .empty_o       ( buf_empty     ),
        .full_o        ( is_full_o     )
    );

    fq_record_builder u_builder (
        .event_i  ( head_event  ),
        .record_o ( head_record )
    );

    fq_queue_ctrl u_ctrl (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .regs_i        ( regs_i      ),
        .head_record_i ( head_record ),
        .buf_empty_i   ( buf_empty   ),
        .wr_done_i     ( wr_done     ),
        .wr_err_i      ( wr_err      ),
        .status_o      ( status_o    ),
        .buf_pop_o     ( buf_pop     ),
        .wr_start_o    ( wr_start    ),
        .wr_record_o   ( wr_record   ),
        .wr_addr_o     ( wr_addr     )
    );

    fq_burst_writer u_writer (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .start_i   ( wr_start  ),
        .record_i  ( wr_record ),
        .addr_i    ( wr_addr   ),
        .mem_rsp_i ( mem_rsp_i ),
        .mem_req_o ( mem_req_o ),
        .done_o    ( wr_done   ),
        .err_o     ( wr_err    )
    );

endmodule

// ==== verif/fq_mem_model.sv ====
// Write memory responder
`timescale 1ns/1ps

module fq_mem_model (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  fq_bus_pkg::wr_req_t                 req_i,
    input  logic                                stall_i,  // Hold off the address phase
    input  logic                                err_i,    // Answer with SLVERR
    output fq_bus_pkg::wr_rsp_t                 rsp_o,
    output logic [fq_types_pkg::PADDR_W-1:0]    addr_o,   // Address of the last burst
    output logic [fq_bus_pkg::BEATS-1:0][fq_bus_pkg::BEAT_W-1:0] data_o,
    output logic [1:0]                          beat_o    // Index of the next beat
);

    integer     seed = 89;
    logic [1:0] aw_wait_q, w_wait_q;  // Cycles left before ready
    logic       b_pend_q;             // Response owed

    assign rsp_o.aw_ready = req_i.aw_valid & (aw_wait_q == 2'd0) & ~stall_i;
    assign rsp_o.w_ready  = req_i.w_valid & (w_wait_q == 2'd0);
    assign rsp_o.b_valid  = b_pend_q;
    assign rsp_o.b_resp   = err_i ? fq_bus_pkg::SLVERR : fq_bus_pkg::OKAY;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_wait_q <= 2'd0;
            w_wait_q  <= 2'd0;
            b_pend_q  <= 1'b0;
            beat_o    <= 2'd0;
            addr_o    <= '0;
            data_o    <= '0;
        end else begin
            // Address phase
            if (rsp_o.aw_ready) begin
                addr_o    <= req_i.aw_addr;
                aw_wait_q <= 2'($random(seed));  // Delay for the next burst
            end else if (req_i.aw_valid && aw_wait_q != 2'd0) begin
                aw_wait_q <= aw_wait_q - 2'd1;
            end

            // Data phase, one doubleword per beat
            if (rsp_o.w_ready) begin
                data_o[beat_o] <= req_i.w_data;
                beat_o         <= beat_o + 2'd1;    // Wraps after beat 3
                w_wait_q       <= 2'($random(seed));
                if (req_i.w_last) b_pend_q <= 1'b1;
            end else if (req_i.w_valid && w_wait_q != 2'd0) begin
                w_wait_q <= w_wait_q - 2'd1;
            end

            if (b_pend_q && req_i.b_ready) b_pend_q <= 1'b0;  // Response taken
        end
    end

endmodule

// ==== verif/fq_handler_tb.sv ====
// Fault queue handler testbench
`timescale 1ns/1ps

module fq_handler_tb;

    localparam int unsigned AW             = fq_types_pkg::PADDR_W;
    localparam int          TIMEOUT_CYCLES = 4000;   // Six tests, 600 cycles at most each
    localparam logic [43:0] BASE_PPN       = 44'h0000ABCDE01;
    localparam logic [4:0]  Q_SIZE         = 5'd3;   // 16 entries

    logic clk   = 1'b0;
    logic rst_n = 1'b0;

    fq_types_pkg::fq_regs_t   regs;
    fq_types_pkg::fq_status_t status;
    fq_types_pkg::fq_event_t  ev;
    fq_bus_pkg::wr_req_t      mem_req;
    fq_bus_pkg::wr_rsp_t      mem_rsp;
    logic                     event_valid, is_full;

    logic                 en, ie, mem_err, mem_stall, expect_full;
    logic [31:0]          head;
    logic [31:0]          sw_tail = '0;   // Software copy of the queue registers
    logic                 sw_mf   = 1'b0;
    logic                 sw_of   = 1'b0;
    logic                 clear_req = 1'b0, clear_ack = 1'b0;  // Flag clear request
    logic                 wb_pend;
    logic [31:0]          wb_tail;
    logic                 wb_mf, wb_of;
    logic                 en_model;                            // Registered enable
    logic [AW-1:0]        mem_addr, exp_addr;
    logic [3:0][63:0]     mem_data;
    logic [1:0]           mem_beat;
    logic [255:0]         exp_rec [16];                        // Records in write order
    logic [255:0]         exp_head;
    logic [3:0]           exp_wr = 4'd0, exp_rd;
    logic [31:0]          idx_mask, tail_next;
    logic                 q_full;
    integer               seed = 89;
    int                   cycles = 0;
    int                   errors = 0, err_start = 0, tests_run = 0, tests_ok = 0;
    string                test_name;

    always #20 clk = ~clk;

    fq_handler UUT (
        .clk_i         ( clk         ),
        .rst_ni        ( rst_n       ),
        .regs_i        ( regs        ),
        .event_valid_i ( event_valid ),
        .event_i       ( ev          ),
        .status_o      ( status      ),
        .is_full_o     ( is_full     ),
        .mem_req_o     ( mem_req     ),
        .mem_rsp_i     ( mem_rsp     )
    );

    fq_mem_model u_mem (
        .clk_i   ( clk       ),
        .rst_ni  ( rst_n     ),
        .req_i   ( mem_req   ),
        .stall_i ( mem_stall ),
        .err_i   ( mem_err   ),
        .rsp_o   ( mem_rsp   ),
        .addr_o  ( mem_addr  ),
        .data_o  ( mem_data  ),
        .beat_o  ( mem_beat  )
    );

    always_comb begin
        regs.base_ppn = BASE_PPN;
        regs.size     = Q_SIZE;
        regs.en       = en;
        regs.ie       = ie;
        regs.head     = head;
        regs.tail     = sw_tail;
        regs.mf       = sw_mf;
        regs.of       = sw_of;
    end

    // Queue arithmetic by the spec rules
    assign idx_mask  = (32'd2 << regs.size) - 32'd1;
    assign tail_next = (regs.tail + 32'd1) & idx_mask;
    assign q_full    = (tail_next == regs.head);
    assign exp_addr  = AW'(regs.base_ppn) * AW'(4096) + AW'(regs.tail & idx_mask) * AW'(32);
    assign exp_head  = exp_rec[exp_rd];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_model <= 1'b0;
            wb_pend  <= 1'b0;
            exp_rd   <= 4'd0;
        end else begin
            en_model <= regs.en;   // en only ever rises here
            wb_pend  <= status.wen;
            if (status.wen) begin
                wb_tail <= status.tail;
                wb_mf   <= status.mf;
                wb_of   <= status.of;
            end
            if (mem_req.b_ready) exp_rd <= exp_rd + 4'd1;  // One record retired
        end
    end

    // Register file update lands on the falling edge
    always @(negedge clk) begin
        if (wb_pend) begin
            sw_tail <= wb_tail;
            sw_mf   <= wb_mf;
            sw_of   <= wb_of;
        end else if (clear_req != clear_ack) begin
            sw_mf     <= 1'b0;   // Software clears both flags
            sw_of     <= 1'b0;
            clear_ack <= clear_req;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic note_mismatch(input string what, input logic [255:0] exp_v,
                                 input logic [255:0] act_v);
        $display("Mismatch in %s: %s expected %0h, actual %0h", test_name, what, exp_v, act_v);
        errors = errors + 1;
    endtask

    task automatic note_failure(input string text);
        $display("Error in %s: %s", test_name, text);
        errors = errors + 1;
    endtask

    // Enable handshake writes tail 0 with flags clear
    assert property (@(posedge clk) disable iff (!rst_n)
        regs.en && !en_model |-> {status.wen, status.mf, status.of, status.tail} == {3'b100, 32'h0})
        else note_mismatch("wen/mf/of/tail", 256'({3'b100, 32'h0}),
            256'($sampled({status.wen, status.mf, status.of, status.tail})));

    assert property (@(posedge clk) disable iff (!rst_n)
        {status.busy, status.on} == {regs.en != en_model, regs.en | en_model})
        else note_mismatch("busy/on", 256'($sampled({regs.en != en_model, regs.en | en_model})),
            256'($sampled({status.busy, status.on})));

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.b_ready |-> mem_addr == exp_addr)
        else note_mismatch("address", 256'($sampled(exp_addr)), 256'($sampled(mem_addr)));

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.b_ready |-> mem_data == exp_head)
        else note_mismatch("record", $sampled(exp_head), 256'($sampled(mem_data)));

    // Good response advances tail
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.b_ready && mem_rsp.b_resp == fq_bus_pkg::OKAY
        |-> {status.wen, status.ip, status.mf, status.tail} == {1'b1, regs.ie, 1'b0, tail_next})
        else note_mismatch("wen/ip/mf/tail", 256'($sampled({1'b1, regs.ie, 1'b0, tail_next})),
            256'($sampled({status.wen, status.ip, status.mf, status.tail})));

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.b_ready && mem_rsp.b_resp != fq_bus_pkg::OKAY
        |-> {status.wen, status.ip, status.mf, status.tail} == {1'b1, regs.ie, 1'b1, regs.tail})
        else note_mismatch("wen/ip/mf/tail", 256'($sampled({1'b1, regs.ie, 1'b1, regs.tail})),
            256'($sampled({status.wen, status.ip, status.mf, status.tail})));

    assert property (@(posedge clk) disable iff (!rst_n)
        status.wen && status.of && !regs.of |-> {q_full, status.ip} == {1'b1, regs.ie})
        else note_mismatch("full/ip", 256'($sampled({1'b1, regs.ie})),
            256'($sampled({q_full, status.ip})));

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.aw_valid |-> !q_full && !regs.mf && !regs.of)
        else note_failure("burst started with the queue full or a fault flag set");

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.w_valid && mem_rsp.w_ready |-> mem_req.w_last == (mem_beat == 2'd3))
        else note_failure("last-beat flag not on the fourth beat");

    assert property (@(posedge clk) disable iff (!rst_n)
        expect_full |-> is_full)
        else note_failure("event buffer not full with four events waiting");

    // Record layout and reporting rules
    function automatic logic [255:0] expected_record(input fq_types_pkg::fq_event_t e);
        logic        req;   // Requester fields reported
        logic [63:0] dw0, dw2, dw3;
        req = (e.ttyp != fq_types_pkg::TTYP_NONE);
        dw0 = {req ? e.did : 24'h0, e.ttyp, req & e.pv & e.priv, req & e.pv,
               (req && e.pv) ? e.pid : 20'h0, e.cause};
        dw2 = (e.ttyp == fq_types_pkg::PCIE_MSG) ? 64'h0 : e.iova;
        dw3 = e.guest_pf ? {21'h0, e.gpa, 1'b0, e.implicit} : 64'h0;
        return {dw3, dw2, 64'h0, dw0};
    endfunction

    task automatic make_event(input fq_types_pkg::ttyp_e t, input logic pv, input logic gpf,
                              output fq_types_pkg::fq_event_t e);
        e.ttyp     = t;
        e.cause    = 12'($random(seed));
        e.iova     = {32'($random(seed)), 32'($random(seed))};
        e.gpa      = {9'($random(seed)), 32'($random(seed))};
        e.did      = 24'($random(seed));
        e.pv       = pv;
        e.pid      = 20'($random(seed)) | 20'd1;  // Never zero
        e.priv     = 1'b1;
        e.guest_pf = gpf;
        e.implicit = 1'b1;
    endtask

    // One rising edge of valid per event
    task automatic send_event(input fq_types_pkg::fq_event_t e);
        @(negedge clk);
        ev                = e;
        event_valid       = 1'b1;
        exp_rec[exp_wr]   = expected_record(e);
        exp_wr            = exp_wr + 4'd1;
        @(negedge clk);
        event_valid = 1'b0;
    endtask

    // Records retired and the last register write landed
    task automatic wait_written();
        while (exp_rd != exp_wr || wb_pend) @(negedge clk);  // Bounded by the cycle counter
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic close_test();
        tests_run = tests_run + 1;
        if (errors == err_start) tests_ok = tests_ok + 1;
        $display("%-14s done, %0d errors", test_name, errors - err_start);
    endtask

    initial begin : stimulus
        fq_types_pkg::fq_event_t e;
        en          = 1'b0;
        ie          = 1'b0;
        head        = '0;
        event_valid = 1'b0;
        ev          = '0;
        mem_err     = 1'b0;
        mem_stall   = 1'b0;
        expect_full = 1'b0;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("enable");
        en = 1'b1;
        ie = 1'b1;
        do @(negedge clk); while (status.busy);
        close_test();

        start_test("single");
        make_event(fq_types_pkg::TR_READ, 1'b1, 1'b0, e);
        send_event(e);
        wait_written();
        close_test();

        start_test("fields");
        make_event(fq_types_pkg::TTYP_NONE, 1'b1, 1'b0, e);
        send_event(e);
        make_event(fq_types_pkg::PCIE_MSG, 1'b1, 1'b0, e);
        send_event(e);
        make_event(fq_types_pkg::TR_WRITE, 1'b0, 1'b0, e);   // pid hidden without pv
        send_event(e);
        make_event(fq_types_pkg::UNTR_READ, 1'b1, 1'b1, e);  // Guest page fault
        send_event(e);
        wait_written();
        close_test();

        start_test("overflow");
        head = (sw_tail + 32'd1) & idx_mask;   // One free slot left
        make_event(fq_types_pkg::TR_WRITE, 1'b1, 1'b0, e);
        send_event(e);
        while (!sw_of) @(negedge clk);
        repeat (8) @(negedge clk);             // Event must stay parked
        head      = 32'd0;                     // Software drained the queue
        clear_req = ~clear_req;
        wait_written();
        close_test();

        start_test("mem_fault");
        ie      = 1'b0;
        mem_err = 1'b1;
        make_event(fq_types_pkg::TR_EXEC, 1'b1, 1'b0, e);
        send_event(e);
        wait_written();
        make_event(fq_types_pkg::UNTR_EXEC, 1'b1, 1'b0, e);  // Held while mf is set
        send_event(e);
        repeat (20) @(negedge clk);
        mem_err   = 1'b0;
        clear_req = ~clear_req;
        wait_written();
        ie = 1'b1;
        close_test();

        start_test("backpressure");
        mem_stall = 1'b1;
        repeat (5) begin
            make_event(fq_types_pkg::UNTR_WRITE, 1'b1, 1'b0, e);
            send_event(e);
        end
        expect_full = 1'b1;   // First record in flight, four waiting
        repeat (4) @(negedge clk);
        expect_full = 1'b0;
        mem_stall   = 1'b0;
        wait_written();
        close_test();

        $display("Summary: %0d tests, %0d passed, %0d errors", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== fq_handler.f ====
source/fq_types_pkg.sv
source/fq_bus_pkg.sv
source/fq_event_buffer.sv
source/fq_record_builder.sv
source/fq_queue_ctrl.sv
source/fq_burst_writer.sv
source/fq_handler.sv
verif/fq_mem_model.sv
verif/fq_handler_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = fq_handler_tb
FILELIST  = fq_handler.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
